// ==== cpuPatterns.txt ====
// Word 0 is the number of tests, then each test holds: program length, program words,
// input port value, expected output count and the expected output words (all hex)
5
// ALU: ldi, add, sub, and, or, addi with negative results
D
08800019 0907FFFA 19890000 B9800000 22108000 BA000000 52890000 BA800000
5B090000 BB000000 63A00064 BB800000 D8000000
00000000
5
00000013 FFFFFFE1 00000018 FFFFFFFB 00000045
// Memory: st then ld through a base register, and ld with R0 as base
A
08800040 09001234 11080005 01880005 B9800000 02000005 BA000000 02800045
BA800000 D8000000
00000000
3
00001234 02000005 00001234
// Branch: zero, nonzero, positive and negative, each taken and not taken
14
08800000 0907FFFD 09800009 90800001 B9800000 90880001 B9000000 91100001
B9800000 91180001 B9000000 91900001 B8800000 91000001 B8800000 91880001
B9000000 91980001 B9800000 D8000000
00000000
4
FFFFFFFD 00000009 00000000 00000009
// Input: in, out, addi, out
5
B0800000 B8800000 61080001 B9000000 D8000000
CAFE0042
2
CAFE0042 CAFE0043
// Halt alone gives no output
1
D8000000
00000000
0

// ==== vlog.f ====
cpuPkg.sv
regFile.sv
aluUnit.sv
memUnit.sv
ioPorts.sv
ctrlUnit.sv
cpuTop.sv
tbChecker.sv
tbCpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbCpu
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PATTERNS  ?= cpuPatterns.txt
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(PATTERNS)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tbCpu.sv ====
`default_nettype none

module tbCpu;

    localparam int patDepth    = 256;
    localparam int maxOut      = 16;
    localparam int resetCycles = 4;

    logic              clk;
    logic              rstN;
    logic              run;
    cpuPkg::word_t     inData;
    logic              loadEn;
    cpuPkg::memAddr_t  loadAddr;
    cpuPkg::word_t     loadData;
    cpuPkg::word_t     outData;
    logic              outValid;
    logic              halted;

    cpuPkg::word_t     pat [patDepth];
    cpuPkg::word_t     expWords [maxOut];
    int                expCount;
    int                testNum;
    int                numTests;
    logic              idlePhase;
    logic              testEnd;
    int                passCount;
    int                failCount;
    int                cycleCount;
    int                cycleLimit;

    cpuTop DUT (
        .clk, .rstN, .run, .inData, .loadEn, .loadAddr, .loadData,
        .outData, .outValid, .halted
    );

    tbChecker #(.maxOut(maxOut)) outCheck (
        .clk, .outData, .outValid, .halted, .idlePhase, .testEnd,
        .testNum, .expCount, .expWords, .passCount, .failCount
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: halted did not rise within %0d cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    // Longest instruction is 8 steps and loading takes one cycle per word
    function automatic int cycleBudget(input int tests);
        int p;
        int len;
        int outs;
        int total;
        p = 1;
        total = 0;
        for (int t = 0; t < tests; t++) begin
            len   = int'(pat[p]);
            outs  = int'(pat[p + len + 2]);
            total = total + len * 9 + 30;
            p     = p + len + 3 + outs;
        end
        return total;
    endfunction

    task automatic applyReset();
        @(posedge clk);
        rstN      <= 1'b0;
        run       <= 1'b0;
        idlePhase <= 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN      <= 1'b1;
        idlePhase <= 1'b1;
    endtask

    task automatic loadProgram(input int base, input int len, input cpuPkg::word_t portVal);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= cpuPkg::memAddr_t'(i);
            loadData <= pat[base + i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        inData <= portVal;
    endtask

    task automatic pulseRun();
        @(posedge clk);
        run       <= 1'b1;
        idlePhase <= 1'b0;
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic waitHalt();
        @(negedge clk);
        while (!halted) begin
            @(negedge clk);
        end
    endtask

    // One cycle pulse so the checker closes the test, then let it count
    task automatic closeTest();
        @(posedge clk);
        testEnd <= 1'b1;
        @(posedge clk);
        testEnd <= 1'b0;
        @(negedge clk);
    endtask

    initial begin
        int ptr;
        int progLen;
        int outLen;
        int t;
        rstN      <= 1'b0;
        run       <= 1'b0;
        inData    <= '0;
        loadEn    <= 1'b0;
        loadAddr  <= '0;
        loadData  <= '0;
        idlePhase <= 1'b0;
        testEnd   <= 1'b0;
        expCount = 0;
        testNum  = 0;
        $readmemh("cpuPatterns.txt", pat);
        numTests   = int'(pat[0]);
        cycleLimit = cycleBudget(numTests);
        ptr = 1;
        for (t = 0; t < numTests; t++) begin
            progLen  = int'(pat[ptr]);
            outLen   = int'(pat[ptr + progLen + 2]);
            testNum  = t + 1;
            expCount = outLen;
            for (int i = 0; i < outLen; i++) begin
                expWords[i] = pat[ptr + progLen + 3 + i];
            end
            applyReset();
            loadProgram(ptr + 1, progLen, pat[ptr + progLen + 1]);
            pulseRun();
            waitHalt();
            closeTest();
            ptr = ptr + progLen + 3 + outLen;
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", numTests, passCount, failCount);
        if (failCount == 0 && passCount == numTests) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tbChecker.sv ====
`default_nettype none

module tbChecker #(
    parameter int maxOut = 16
) (
    input  wire                 clk,
    input  wire cpuPkg::word_t  outData,
    input  wire                 outValid,
    input  wire                 halted,
    input  wire                 idlePhase,
    input  wire                 testEnd,
    input  wire [31:0]          testNum,
    input  wire [31:0]          expCount,
    input  wire cpuPkg::word_t  expWords [maxOut],
    output int                  passCount,
    output int                  failCount
);

    int outIdx;
    bit testErr;

    // Outputs settle after the rising edge, so they are sampled on the falling edge
    always @(negedge clk) begin
        if (idlePhase) begin
            if (outValid !== 1'b0 || halted !== 1'b0) begin
                $display("test %0d: outValid or halted is high before run at time %0t",
                         testNum, $time);
                testErr = 1'b1;
            end
        end else begin
            if (outValid === 1'b1) begin
                if (outIdx >= int'(expCount)) begin
                    $display("test %0d: extra output %h after the %0d expected ones",
                             testNum, outData, expCount);
                    testErr = 1'b1;
                end else if (outData !== expWords[outIdx]) begin
                    $display("mismatch at time %0t: test %0d output %0d is %h, expected %h",
                             $time, testNum, outIdx, outData, expWords[outIdx]);
                    testErr = 1'b1;
                end
                outIdx = outIdx + 1;
            end
            if (testEnd) begin
                if (outIdx < int'(expCount)) begin
                    $display("test %0d: only %0d of %0d expected outputs arrived",
                             testNum, outIdx, expCount);
                    testErr = 1'b1;
                end
                if (halted !== 1'b1) begin
                    $display("test %0d: halted dropped before the end of the test", testNum);
                    testErr = 1'b1;
                end
                if (testErr) begin
                    failCount = failCount + 1;
                    $display("test %0d: FAIL", testNum);
                end else begin
                    passCount = passCount + 1;
                    $display("test %0d: PASS, %0d outputs", testNum, outIdx);
                end
                // Next test starts with no outputs and no errors
                outIdx  = 0;
                testErr = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`default_nettype none

module cpuTop (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    run,
    input  wire cpuPkg::word_t     inData,
    input  wire                    loadEn,
    input  wire cpuPkg::memAddr_t  loadAddr,
    input  wire cpuPkg::word_t     loadData,
    output cpuPkg::word_t          outData,
    output logic                   outValid,
    output logic                   halted
);

    cpuPkg::word_t  busOut;
    cpuPkg::word_t  pc;
    cpuPkg::word_t  ir;
    cpuPkg::word_t  regOut;
    cpuPkg::word_t  cSignExt;
    cpuPkg::word_t  zHigh;
    cpuPkg::word_t  zLow;
    cpuPkg::word_t  mdrData;
    cpuPkg::word_t  inPortOut;
    cpuPkg::aluOp_t aluOp;
    logic gra, grb, grc, gprIn, gprOut, baOut;
    logic yIn, zIn, conIn, conFlag, pcIn, pcOut, irIn;
    logic marIn, mdrIn, mdrOut, read, write;
    logic zHighOut, zLowOut, cOut, inIn, inOut, outIn;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcIn) begin
            pc <= busOut;
        end
    end

    always_ff @(posedge clk) begin
        if (irIn) begin
            ir <= busOut;
        end
    end

    // Bus multiplexer, zero when nothing drives it
    always_comb begin
        busOut = '0;
        if (gprOut) begin
            busOut = regOut;
        end else if (zHighOut) begin
            busOut = zHigh;
        end else if (zLowOut) begin
            busOut = zLow;
        end else if (pcOut) begin
            busOut = pc;
        end else if (mdrOut) begin
            busOut = mdrData;
        end else if (inOut) begin
            busOut = inPortOut;
        end else if (cOut) begin
            busOut = cSignExt;
        end
    end

    busOneDriver: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({gprOut, zHighOut, zLowOut, pcOut, mdrOut, inOut, cOut}))
        else $error("bus driven by more than one source");

    ctrlUnit ctrl (
        .clk, .rstN, .run, .ir, .conFlag,
        .gra, .grb, .grc, .gprIn, .gprOut, .baOut, .yIn, .zIn, .aluOp, .conIn,
        .pcIn, .pcOut, .irIn, .marIn, .mdrIn, .mdrOut, .read, .write,
        .zHighOut, .zLowOut, .cOut, .inIn, .inOut, .outIn, .halted
    );

    regFile regs (
        .clk, .rstN, .ir, .gra, .grb, .grc, .gprIn, .gprOut, .baOut, .busOut,
        .regOut, .cSignExt
    );

    aluUnit alu (
        .clk, .rstN, .busOut, .yIn, .zIn, .aluOp, .conIn,
        .cond(ir[cpuPkg::condLsb +: cpuPkg::condWidth]),
        .zHigh, .zLow, .conFlag
    );

    memUnit mem (
        .clk, .rstN, .busOut, .marIn, .mdrIn, .read, .write,
        .loadEn, .loadAddr, .loadData,
        .mdrOut(mdrData)
    );

    ioPorts io (
        .clk, .rstN, .inData, .inIn, .busOut, .outIn,
        .inPortOut, .outData, .outValid
    );

endmodule

`default_nettype wire

// ==== ctrlUnit.sv ====
`default_nettype none

module ctrlUnit (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire                 run,
    input  wire cpuPkg::word_t  ir,
    input  wire                 conFlag,
    output logic                gra,
    output logic                grb,
    output logic                grc,
    output logic                gprIn,
    output logic                gprOut,
    output logic                baOut,
    output logic                yIn,
    output logic                zIn,
    output cpuPkg::aluOp_t      aluOp,
    output logic                conIn,
    output logic                pcIn,
    output logic                pcOut,
    output logic                irIn,
    output logic                marIn,
    output logic                mdrIn,
    output logic                mdrOut,
    output logic                read,
    output logic                write,
    output logic                zHighOut,
    output logic                zLowOut,
    output logic                cOut,
    output logic                inIn,
    output logic                inOut,
    output logic                outIn,
    output logic                halted
);

    cpuPkg::step_t   state;
    cpuPkg::step_t   nextState;
    cpuPkg::opcode_t op;
    logic            isAluRR;
    logic            isMem;
    logic            usesConst;

    assign op = cpuPkg::opcode_t'(ir[cpuPkg::opLsb +: $bits(cpuPkg::opcode_t)]);

    assign isAluRR   = (op == cpuPkg::opAdd) || (op == cpuPkg::opSub) ||
                       (op == cpuPkg::opAnd) || (op == cpuPkg::opOr);
    assign isMem     = (op == cpuPkg::opLd) || (op == cpuPkg::opSt);
    assign usesConst = isMem || (op == cpuPkg::opLdi) || (op == cpuPkg::opAddi);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::stepIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::stepIdle: nextState = run ? cpuPkg::stepT0 : cpuPkg::stepIdle;
            cpuPkg::stepT0:   nextState = cpuPkg::stepT1;
            cpuPkg::stepT1:   nextState = cpuPkg::stepT2;
            cpuPkg::stepT2:   nextState = cpuPkg::stepT3;
            cpuPkg::stepT3: begin
                if (op == cpuPkg::opHalt) begin
                    nextState = cpuPkg::stepHalt;
                end else if (isAluRR || usesConst || op == cpuPkg::opBr) begin
                    nextState = cpuPkg::stepT4;
                end else begin
                    nextState = cpuPkg::stepT0;
                end
            end
            cpuPkg::stepT4:   nextState = cpuPkg::stepT5;
            cpuPkg::stepT5:   nextState = isMem ? cpuPkg::stepT6 : cpuPkg::stepT0;
            cpuPkg::stepT6:   nextState = cpuPkg::stepT7;
            cpuPkg::stepT7:   nextState = cpuPkg::stepT0;
            default:          nextState = cpuPkg::stepHalt;
        endcase
    end

    always_comb begin
        {gra, grb, grc, gprIn, gprOut, baOut, yIn, zIn, conIn} = '0;
        {pcIn, pcOut, irIn, marIn, mdrIn, mdrOut, read, write} = '0;
        {zHighOut, zLowOut, cOut, inIn, inOut, outIn} = '0;
        aluOp = cpuPkg::aluPassB;
        case (state)
            cpuPkg::stepT0: begin
                {pcOut, marIn, zIn} = 3'b111;
                aluOp = cpuPkg::aluInc;
            end
            // Y keeps the incremented PC as the branch base
            cpuPkg::stepT1: {zLowOut, pcIn, read, mdrIn, yIn} = 5'b11111;
            // Input port is sampled on every fetch so in needs one step
            cpuPkg::stepT2: {mdrOut, irIn, inIn} = 3'b111;
            cpuPkg::stepT3: begin
                if (isAluRR || usesConst) begin
                    {grb, gprOut, yIn} = 3'b111;
                    baOut = usesConst && (op != cpuPkg::opAddi);
                end else if (op == cpuPkg::opBr) begin
                    {gra, gprOut, conIn} = 3'b111;
                end else if (op == cpuPkg::opIn) begin
                    {inOut, gra, gprIn} = 3'b111;
                end else if (op == cpuPkg::opOut) begin
                    {gra, gprOut, outIn} = 3'b111;
                end
            end
            cpuPkg::stepT4: begin
                zIn = 1'b1;
                case (op)
                    cpuPkg::opAdd: {grc, gprOut, aluOp} = {2'b11, cpuPkg::aluAdd};
                    cpuPkg::opSub: {grc, gprOut, aluOp} = {2'b11, cpuPkg::aluSub};
                    cpuPkg::opAnd: {grc, gprOut, aluOp} = {2'b11, cpuPkg::aluAnd};
                    cpuPkg::opOr:  {grc, gprOut, aluOp} = {2'b11, cpuPkg::aluOr};
                    default:       {cOut, aluOp} = {1'b1, cpuPkg::aluAdd};
                endcase
            end
            cpuPkg::stepT5: begin
                if (isMem) begin
                    {zLowOut, marIn} = 2'b11;
                end else if (op == cpuPkg::opBr) begin
                    {zLowOut, pcIn} = {2{conFlag}};
                end else begin
                    {zLowOut, gra, gprIn} = 3'b111;
                end
            end
            cpuPkg::stepT6: begin
                if (op == cpuPkg::opLd) begin
                    {read, mdrIn} = 2'b11;
                end else begin
                    {gra, gprOut, mdrIn} = 3'b111;
                end
            end
            cpuPkg::stepT7: begin
                if (op == cpuPkg::opLd) begin
                    {mdrOut, gra, gprIn} = 3'b111;
                end else begin
                    write = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign halted = (state == cpuPkg::stepHalt);

    haltIsFinal: assert property (@(posedge clk) disable iff (!rstN)
        state == cpuPkg::stepHalt |=> state == cpuPkg::stepHalt)
        else $error("control left halt without reset");

endmodule

`default_nettype wire

// ==== ioPorts.sv ====
`default_nettype none

module ioPorts (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire cpuPkg::word_t  inData,
    input  wire                 inIn,
    input  wire cpuPkg::word_t  busOut,
    input  wire                 outIn,
    output cpuPkg::word_t       inPortOut,
    output cpuPkg::word_t       outData,
    output logic                outValid
);

    always_ff @(posedge clk) begin
        if (inIn) begin
            inPortOut <= inData;
        end
        if (outIn) begin
            outData <= busOut;
        end
    end

    // Valid follows the output register capture by one cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= outIn;
        end
    end

endmodule

`default_nettype wire

// ==== memUnit.sv ====
`default_nettype none

module memUnit (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire cpuPkg::word_t     busOut,
    input  wire                    marIn,
    input  wire                    mdrIn,
    input  wire                    read,
    input  wire                    write,
    input  wire                    loadEn,
    input  wire cpuPkg::memAddr_t  loadAddr,
    input  wire cpuPkg::word_t     loadData,
    output cpuPkg::word_t          mdrOut
);

    cpuPkg::memAddr_t mar;
    cpuPkg::word_t    mdr;
    cpuPkg::word_t    ram [cpuPkg::memDepth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= busOut[$bits(cpuPkg::memAddr_t)-1:0];
        end
    end

    // MDR loads RAM data on a read, bus data otherwise
    always_ff @(posedge clk) begin
        if (mdrIn) begin
            mdr <= read ? ram[mar] : busOut;
        end
    end

    // Program load port shares the write side with st
    always_ff @(posedge clk) begin
        if (loadEn) begin
            ram[loadAddr] <= loadData;
        end else if (write) begin
            ram[mar] <= mdr;
        end
    end

    assign mdrOut = mdr;

    loadNotDuringWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(loadEn && write))
        else $error("program load collided with a store");

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
`default_nettype none

module aluUnit (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire cpuPkg::word_t                  busOut,
    input  wire                                 yIn,
    input  wire                                 zIn,
    input  wire cpuPkg::aluOp_t                 aluOp,
    input  wire                                 conIn,
    input  wire [cpuPkg::condWidth-1:0]         cond,
    output cpuPkg::word_t                       zHigh,
    output cpuPkg::word_t                       zLow,
    output logic                                conFlag
);

    cpuPkg::word_t  yReg;
    cpuPkg::dword_t zReg;
    cpuPkg::dword_t aluResult;
    logic           condMet;

    // A input is Y, B input is the bus
    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: aluResult = {{32{yReg[31]}}, yReg} + {{32{busOut[31]}}, busOut};
            cpuPkg::aluSub: aluResult = {{32{yReg[31]}}, yReg} - {{32{busOut[31]}}, busOut};
            cpuPkg::aluAnd: aluResult = {32'b0, yReg & busOut};
            cpuPkg::aluOr:  aluResult = {32'b0, yReg | busOut};
            cpuPkg::aluInc: aluResult = {32'b0, busOut + 32'd1};
            default:        aluResult = {32'b0, busOut};
        endcase
    end

    always_ff @(posedge clk) begin
        if (yIn) begin
            yReg <= busOut;
        end
        if (zIn) begin
            zReg <= aluResult;
        end
    end

    assign zHigh = zReg[63:32];
    assign zLow  = zReg[31:0];

    // Positive means sign bit clear
    always_comb begin
        case (cond)
            2'b00:   condMet = (busOut == '0);
            2'b01:   condMet = (busOut != '0);
            2'b10:   condMet = !busOut[31];
            default: condMet = busOut[31];
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            conFlag <= 1'b0;
        end else if (conIn) begin
            conFlag <= condMet;
        end
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire cpuPkg::word_t  ir,
    input  wire                 gra,
    input  wire                 grb,
    input  wire                 grc,
    input  wire                 gprIn,
    input  wire                 gprOut,
    input  wire                 baOut,
    input  wire cpuPkg::word_t  busOut,
    output cpuPkg::word_t       regOut,
    output cpuPkg::word_t       cSignExt
);

    cpuPkg::regIdx_t sel;
    cpuPkg::word_t   regs [cpuPkg::numRegs];

    // Select and encode from the IR register fields
    always_comb begin
        sel = '0;
        if (gra) begin
            sel = ir[cpuPkg::raLsb +: $bits(cpuPkg::regIdx_t)];
        end else if (grb) begin
            sel = ir[cpuPkg::rbLsb +: $bits(cpuPkg::regIdx_t)];
        end else if (grc) begin
            sel = ir[cpuPkg::rcLsb +: $bits(cpuPkg::regIdx_t)];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < cpuPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (gprIn) begin
            regs[sel] <= busOut;
        end
    end

    // R0 used as a base address reads as zero
    always_comb begin
        regOut = '0;
        if (gprOut && !(baOut && sel == '0)) begin
            regOut = regs[sel];
        end
    end

    assign cSignExt = {{($bits(cpuPkg::word_t) - cpuPkg::constWidth){ir[cpuPkg::constWidth-1]}},
                       ir[cpuPkg::constWidth-1:0]};

    // Control must pick a single IR field per step
    selOneField: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({gra, grb, grc}))
        else $error("more than one register field selected");

endmodule

`default_nettype wire

// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [8:0]  memAddr_t;
    typedef logic [3:0]  regIdx_t;

    // Instruction field positions
    localparam int opLsb      = 27;
    localparam int raLsb      = 23;
    localparam int rbLsb      = 19;
    localparam int rcLsb      = 15;
    localparam int constWidth = 19;
    // Branch condition lives in the rb field
    localparam int condLsb    = 19;
    localparam int condWidth  = 2;

    localparam int numRegs  = 16;
    localparam int memDepth = 512;

    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opAddi = 5'b01100,
        opBr   = 5'b10010,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcode_t;

    // ld and st use two extra memory steps after t5
    typedef enum logic [3:0] {
        stepIdle,
        stepT0,
        stepT1,
        stepT2,
        stepT3,
        stepT4,
        stepT5,
        stepT6,
        stepT7,
        stepHalt
    } step_t;

    typedef enum logic [2:0] {
        aluPassB,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluInc
    } aluOp_t;

endpackage

`default_nettype wire
